//--- rtl/rope_pkg.sv
// Shared widths, item word layout, game constants and controller states.
// Item words keep all unused bits at zero.
// Frame time is a handful of clocks so simulation stays short.
package rope_pkg;

    typedef logic [9:0]  coord_t;
    typedef logic [7:0]  angle_t;
    typedef logic [9:0]  length_t;
    typedef logic [8:0]  trig_t;
    typedef logic [3:0]  item_addr_t;
    typedef logic [31:0] item_word_t;
    typedef logic [15:0] score_t;

    // item word fields
    localparam int ITEM_X_LSB       = 23;
    localparam int ITEM_X_W         = 9;
    localparam int ITEM_Y_LSB       = 11;
    localparam int ITEM_Y_W         = 8;
    localparam int ITEM_TYPE_LSB    = 2;
    localparam int ITEM_TYPE_W      = 2;
    localparam int ITEM_VISIBLE_BIT = 1;
    localparam int ITEM_TAKEN_BIT   = 0;
    localparam int ITEM_DEPTH       = 16;

    // pivot, rope and swing
    localparam coord_t  ORIGIN_X   = 10'd77;
    localparam coord_t  ORIGIN_Y   = 10'd45;
    localparam length_t ROPE_MIN   = 10'd20;
    localparam length_t DELTA_LEN  = 10'd5;
    localparam angle_t  ANGLE_STEP = 8'd5;
    localparam angle_t  ANGLE_MIN  = 8'd15;
    localparam angle_t  ANGLE_MAX  = 8'd165;
    localparam angle_t  ANGLE_REST = 8'd90;

    // frame pacing
    localparam int FRAME_TICKS  = 8;
    localparam int HEAVY_FRAMES = 3;
    localparam int FRAME_CNT_W  = 8;

    // playfield
    localparam coord_t ITEM_SIZE    = 10'd16;
    localparam coord_t SCREEN_X_MIN = 10'd2;
    localparam coord_t SCREEN_X_MAX = 10'd317;
    localparam coord_t SCREEN_Y_MAX = 10'd237;

    // item values
    localparam score_t SCORE_STONE   = 16'd10;
    localparam score_t SCORE_GOLD    = 16'd20;
    localparam score_t SCORE_DIAMOND = 16'd50;

    typedef enum logic [3:0] {
        idle,
        swing_wait,
        swing_step,
        extend_wait,
        extend_step,
        scan_addr,
        scan_read,
        scan_test,
        retract_wait,
        retract_step,
        collect_write
    } rope_state_t;

endpackage

//--- rtl/swing_trig.sv
// Hook end point from angle and rope length, one cycle of latency.
// Only multiples of 5 degrees between 0 and 180 are looked up correctly.
// Left of the pivot a negative x wraps in 10 bits and reads as off screen.
module swing_trig (
    input  logic               clock,
    input  rope_pkg::angle_t   angle,
    input  rope_pkg::length_t  rope_len,
    output rope_pkg::coord_t   end_x,
    output rope_pkg::coord_t   end_y
);

    rope_pkg::angle_t folded;
    logic [4:0]       sin_idx;
    logic [4:0]       cos_idx;
    rope_pkg::trig_t  sin_mag;
    rope_pkg::trig_t  cos_mag;
    logic [18:0]      prod_x;
    logic [18:0]      prod_y;

    // round(256 * sin) in 5 degree steps
    function automatic rope_pkg::trig_t sin_lut(input logic [4:0] idx);
        case (idx)
            5'd0:    return 9'd0;
            5'd1:    return 9'd22;
            5'd2:    return 9'd44;
            5'd3:    return 9'd66;
            5'd4:    return 9'd88;
            5'd5:    return 9'd108;
            5'd6:    return 9'd128;
            5'd7:    return 9'd147;
            5'd8:    return 9'd165;
            5'd9:    return 9'd181;
            5'd10:   return 9'd196;
            5'd11:   return 9'd210;
            5'd12:   return 9'd222;
            5'd13:   return 9'd232;
            5'd14:   return 9'd241;
            5'd15:   return 9'd247;
            5'd16:   return 9'd252;
            5'd17:   return 9'd255;
            default: return 9'd256;
        endcase
    endfunction

    always_comb begin
        // fold into 0..90, cosine is the mirrored entry
        if (angle > rope_pkg::ANGLE_REST) begin
            folded = rope_pkg::ANGLE_REST + rope_pkg::ANGLE_REST - angle;
        end else begin
            folded = angle;
        end
        sin_idx = 5'(folded / rope_pkg::ANGLE_STEP);
        cos_idx = 5'd18 - sin_idx;
        sin_mag = sin_lut(sin_idx);
        cos_mag = sin_lut(cos_idx);
        prod_x  = 19'(rope_len) * 19'(cos_mag);
        prod_y  = 19'(rope_len) * 19'(sin_mag);
    end

    always_ff @(posedge clock) begin
        end_y <= rope_pkg::ORIGIN_Y + rope_pkg::coord_t'(prod_y >> 8);
        if (angle < rope_pkg::ANGLE_REST) begin
            end_x <= rope_pkg::ORIGIN_X + rope_pkg::coord_t'(prod_x >> 8);
        end else begin
            end_x <= rope_pkg::ORIGIN_X - rope_pkg::coord_t'(prod_x >> 8);
        end
    end

endmodule

//--- rtl/item_table.sv
// Item RAM with a single registered read port.
// Drawing reads win the read address; host loads win the write port.
// The controller sees ctrl_ready low whenever either of them is active.
module item_table (
    input  logic                  clock,
    input  logic                  draw_busy,
    input  rope_pkg::item_addr_t  draw_index,
    input  logic                  load_en,
    input  rope_pkg::item_addr_t  load_addr,
    input  rope_pkg::item_word_t  load_data,
    input  rope_pkg::item_addr_t  ctrl_addr,
    input  rope_pkg::item_word_t  ctrl_wdata,
    input  logic                  ctrl_wen,
    output rope_pkg::item_word_t  item_rdata,
    output logic                  ctrl_ready
);

    rope_pkg::item_word_t mem [rope_pkg::ITEM_DEPTH];
    rope_pkg::item_addr_t rd_addr;

    assign rd_addr    = draw_busy ? draw_index : ctrl_addr;
    assign ctrl_ready = !draw_busy && !load_en;

    always_ff @(posedge clock) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end else if (ctrl_wen && ctrl_ready) begin
            mem[ctrl_addr] <= ctrl_wdata;
        end
        // old data on a same-address write
        item_rdata <= mem[rd_addr];
    end

endmodule

//--- rtl/key_pulse.sv
// Fire key conditioning: two-stage synchronizer and rising edge detect.
// The pulse lasts one frame plus one cycle, so exactly one swing step sees it.
// A new edge during the pulse restarts it.
module key_pulse (
    input  logic clock,
    input  logic resetn,
    input  logic key,
    output logic pulse
);

    logic [1:0]                       sync_q;
    logic                             key_prev;
    logic [rope_pkg::FRAME_CNT_W-1:0] hold_cnt;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            sync_q   <= '0;
            key_prev <= 1'b0;
            hold_cnt <= '0;
        end else begin
            sync_q   <= {sync_q[0], key};
            key_prev <= sync_q[1];
            if (sync_q[1] && !key_prev) begin
                hold_cnt <= rope_pkg::FRAME_CNT_W'(rope_pkg::FRAME_TICKS + 1);
            end else if (hold_cnt != '0) begin
                hold_cnt <= hold_cnt - 1'b1;
            end
        end
    end

    assign pulse = (hold_cnt != '0);

endmodule

//--- rtl/score_counter.sv
// Score accumulator, adds the value of the collected item type.
// The sum wraps at 16 bits; there is no subtraction.
module score_counter (
    input  logic                                 clock,
    input  logic                                 resetn,
    input  logic                                 score_add,
    input  logic [rope_pkg::ITEM_TYPE_W-1:0]     score_type,
    output rope_pkg::score_t                     score
);

    rope_pkg::score_t value;

    always_comb begin
        case (score_type)
            2'd0:    value = rope_pkg::SCORE_STONE;
            2'd1:    value = rope_pkg::SCORE_GOLD;
            // both upper codes are diamonds
            default: value = rope_pkg::SCORE_DIAMOND;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            score <= '0;
        end else if (score_add) begin
            score <= score + value;
        end
    end

endmodule

//--- rtl/rope_controller.sv
// Rope state machine: swing, extend, scan for a hit, retract and collect.
// Scans entries 0 to item_count-1, so at most 15 items take part.
// Table reads and writes only proceed while ctrl_ready is high.
// Rope length grows as an extend wait ends, so the end point has settled
// by the time the scan looks at it.
module rope_controller (
    input  logic                              clock,
    input  logic                              resetn,
    input  logic                              enable,
    input  logic                              fire,
    input  rope_pkg::item_addr_t              item_count,
    input  rope_pkg::coord_t                  end_x,
    input  rope_pkg::coord_t                  end_y,
    input  rope_pkg::item_word_t              item_rdata,
    input  logic                              ctrl_ready,
    output rope_pkg::angle_t                  angle,
    output rope_pkg::length_t                 rope_len,
    output rope_pkg::item_addr_t              ctrl_addr,
    output rope_pkg::item_word_t              ctrl_wdata,
    output logic                              ctrl_wen,
    output logic                              score_add,
    output logic [rope_pkg::ITEM_TYPE_W-1:0]  score_type
);

    rope_pkg::rope_state_t            state;
    logic [rope_pkg::FRAME_CNT_W-1:0] frame_cnt;
    logic [rope_pkg::FRAME_CNT_W-1:0] frame_last;
    logic                             frame_done;
    logic                             swing_up;
    logic                             carrying;
    rope_pkg::item_word_t             item_q;
    rope_pkg::coord_t                 item_x;
    rope_pkg::coord_t                 item_y;
    logic                             hit;
    logic                             off_screen;

    // heavier load slows the retract
    always_comb begin
        if (state == rope_pkg::retract_wait && carrying) begin
            frame_last = rope_pkg::FRAME_CNT_W'(
                rope_pkg::FRAME_TICKS * (1 + rope_pkg::HEAVY_FRAMES) - 1);
        end else begin
            frame_last = rope_pkg::FRAME_CNT_W'(rope_pkg::FRAME_TICKS - 1);
        end
        frame_done = (frame_cnt == frame_last);
    end

    always_comb begin
        item_x = rope_pkg::coord_t'(item_q[rope_pkg::ITEM_X_LSB +: rope_pkg::ITEM_X_W]);
        item_y = rope_pkg::coord_t'(item_q[rope_pkg::ITEM_Y_LSB +: rope_pkg::ITEM_Y_W]);
        hit = item_q[rope_pkg::ITEM_VISIBLE_BIT] && !item_q[rope_pkg::ITEM_TAKEN_BIT]
            && (item_x < end_x) && (end_x <= item_x + rope_pkg::ITEM_SIZE)
            && (item_y < end_y) && (end_y <= item_y + rope_pkg::ITEM_SIZE);
        off_screen = (end_x < rope_pkg::SCREEN_X_MIN) || (end_x > rope_pkg::SCREEN_X_MAX)
            || (end_y > rope_pkg::SCREEN_Y_MAX);
    end

    // table write data: mark taken on a hit, clear the entry on collect
    always_comb begin
        ctrl_wdata = item_q;
        if (state == rope_pkg::collect_write) begin
            ctrl_wdata[rope_pkg::ITEM_VISIBLE_BIT] = 1'b0;
            ctrl_wdata[rope_pkg::ITEM_TAKEN_BIT]   = 1'b0;
        end else begin
            ctrl_wdata[rope_pkg::ITEM_TAKEN_BIT] = 1'b1;
        end
    end

    assign ctrl_wen = ctrl_ready
        && ((state == rope_pkg::scan_test && hit) || state == rope_pkg::collect_write);
    assign score_add  = ctrl_ready && (state == rope_pkg::collect_write);
    assign score_type = item_q[rope_pkg::ITEM_TYPE_LSB +: rope_pkg::ITEM_TYPE_W];

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state     <= rope_pkg::idle;
            frame_cnt <= '0;
            swing_up  <= 1'b0;
            carrying  <= 1'b0;
            angle     <= rope_pkg::ANGLE_REST;
            rope_len  <= rope_pkg::ROPE_MIN;
            ctrl_addr <= '0;
        end else begin
            case (state)
                rope_pkg::idle: begin
                    frame_cnt <= '0;
                    if (enable) begin
                        state <= rope_pkg::swing_wait;
                    end
                end
                rope_pkg::swing_wait, rope_pkg::extend_wait, rope_pkg::retract_wait: begin
                    frame_cnt <= frame_cnt + 1'b1;
                    if (frame_done) begin
                        frame_cnt <= '0;
                        if (state == rope_pkg::swing_wait) begin
                            state <= rope_pkg::swing_step;
                        end else if (state == rope_pkg::extend_wait) begin
                            rope_len <= rope_len + rope_pkg::DELTA_LEN;
                            state    <= rope_pkg::extend_step;
                        end else begin
                            state <= rope_pkg::retract_step;
                        end
                    end
                end
                rope_pkg::swing_step: begin
                    if (fire) begin
                        // drop at the current angle
                        state <= rope_pkg::extend_wait;
                    end else begin
                        state <= rope_pkg::swing_wait;
                        if (swing_up) begin
                            angle <= angle + rope_pkg::ANGLE_STEP;
                            if (angle + rope_pkg::ANGLE_STEP == rope_pkg::ANGLE_MAX) begin
                                swing_up <= 1'b0;
                            end
                        end else begin
                            angle <= angle - rope_pkg::ANGLE_STEP;
                            if (angle - rope_pkg::ANGLE_STEP == rope_pkg::ANGLE_MIN) begin
                                swing_up <= 1'b1;
                            end
                        end
                    end
                end
                rope_pkg::extend_step: begin
                    ctrl_addr <= '0;
                    state     <= rope_pkg::scan_addr;
                end
                rope_pkg::scan_addr: begin
                    if (off_screen) begin
                        state <= rope_pkg::retract_wait;
                    end else if (ctrl_addr >= item_count) begin
                        state <= rope_pkg::extend_wait;
                    end else if (ctrl_ready) begin
                        // address goes out this cycle
                        state <= rope_pkg::scan_read;
                    end
                end
                rope_pkg::scan_read: begin
                    item_q <= item_rdata;
                    state  <= rope_pkg::scan_test;
                end
                rope_pkg::scan_test: begin
                    if (!hit) begin
                        ctrl_addr <= ctrl_addr + 1'b1;
                        state     <= rope_pkg::scan_addr;
                    end else if (ctrl_ready) begin
                        // ctrl_addr keeps the carried entry until collect
                        carrying <= 1'b1;
                        state    <= rope_pkg::retract_wait;
                    end
                end
                rope_pkg::retract_step: begin
                    if (rope_len <= rope_pkg::ROPE_MIN + rope_pkg::DELTA_LEN) begin
                        rope_len <= rope_pkg::ROPE_MIN;
                        if (carrying) begin
                            state <= rope_pkg::collect_write;
                        end else begin
                            state <= rope_pkg::swing_wait;
                        end
                    end else begin
                        rope_len <= rope_len - rope_pkg::DELTA_LEN;
                        state    <= rope_pkg::retract_wait;
                    end
                end
                rope_pkg::collect_write: begin
                    if (ctrl_ready) begin
                        carrying <= 1'b0;
                        state    <= rope_pkg::swing_wait;
                    end
                end
                default: begin
                    state <= rope_pkg::idle;
                end
            endcase
        end
    end

endmodule

//--- rtl/rope_top.sv
// Rope block top: key conditioning, controller, end point, item table, score.
// The drawing engine and the host loader sit outside and share the item table.
module rope_top (
    input  logic                  clock,
    input  logic                  resetn,
    input  logic                  enable,
    input  logic                  fire_key,
    input  rope_pkg::item_addr_t  item_count,
    input  logic                  draw_busy,
    input  rope_pkg::item_addr_t  draw_index,
    input  logic                  load_en,
    input  rope_pkg::item_addr_t  load_addr,
    input  rope_pkg::item_word_t  load_data,
    output rope_pkg::coord_t      end_x,
    output rope_pkg::coord_t      end_y,
    output rope_pkg::angle_t      angle,
    output rope_pkg::length_t     rope_len,
    output rope_pkg::score_t      score,
    output rope_pkg::item_word_t  item_rdata
);

    logic                             fire;
    rope_pkg::item_addr_t             ctrl_addr;
    rope_pkg::item_word_t             ctrl_wdata;
    logic                             ctrl_wen;
    logic                             ctrl_ready;
    logic                             score_add;
    logic [rope_pkg::ITEM_TYPE_W-1:0] score_type;

    key_pulse key_pulse_inst (
        .clock  (clock),
        .resetn (resetn),
        .key    (fire_key),
        .pulse  (fire)
    );

    rope_controller rope_controller_inst (
        .clock      (clock),
        .resetn     (resetn),
        .enable     (enable),
        .fire       (fire),
        .item_count (item_count),
        .end_x      (end_x),
        .end_y      (end_y),
        .item_rdata (item_rdata),
        .ctrl_ready (ctrl_ready),
        .angle      (angle),
        .rope_len   (rope_len),
        .ctrl_addr  (ctrl_addr),
        .ctrl_wdata (ctrl_wdata),
        .ctrl_wen   (ctrl_wen),
        .score_add  (score_add),
        .score_type (score_type)
    );

    swing_trig swing_trig_inst (
        .clock    (clock),
        .angle    (angle),
        .rope_len (rope_len),
        .end_x    (end_x),
        .end_y    (end_y)
    );

    item_table item_table_inst (
        .clock      (clock),
        .draw_busy  (draw_busy),
        .draw_index (draw_index),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .ctrl_addr  (ctrl_addr),
        .ctrl_wdata (ctrl_wdata),
        .ctrl_wen   (ctrl_wen),
        .item_rdata (item_rdata),
        .ctrl_ready (ctrl_ready)
    );

    score_counter score_counter_inst (
        .clock      (clock),
        .resetn     (resetn),
        .score_add  (score_add),
        .score_type (score_type),
        .score      (score)
    );

endmodule

//--- sim/tb_clock_gen.sv
// Testbench clock and reset source.
// 4 ns clock period; resetn is held low for the first 4 rising edges.
module tb_clock_gen (
    output logic clock,
    output logic resetn
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    initial begin
        resetn = 1'b0;
        repeat (4) @(posedge clock);
        resetn <= 1'b1;
    end

endmodule

//--- sim/rope_tb.sv
// Testbench for the rope block.
// Random fire times, item types and draw bursts come from one fixed seed.
// The model rebuilds the sine table and end point from the geometry rules.
// Outputs are sampled on the falling edge, inputs change on the rising edge.
module rope_tb;
    timeunit 1ns;
    timeprecision 100ps;

    logic                 clock;
    logic                 resetn;
    logic                 enable;
    logic                 fire_key;
    rope_pkg::item_addr_t item_count;
    logic                 draw_busy;
    rope_pkg::item_addr_t draw_index;
    logic                 load_en;
    rope_pkg::item_addr_t load_addr;
    rope_pkg::item_word_t load_data;
    rope_pkg::coord_t     end_x;
    rope_pkg::coord_t     end_y;
    rope_pkg::angle_t     angle;
    rope_pkg::length_t    rope_len;
    rope_pkg::score_t     score;
    rope_pkg::item_word_t item_rdata;

    // model state
    int                   sin_tab [19];
    rope_pkg::item_word_t shadow [16];
    int                   hit_idx = -1;
    int                   exp_score = 0;
    int                   errors = 0;
    int                   tests = 0;
    int                   failed = 0;
    bit                   timed_out = 0;
    // monitor state
    bit                   have_prev = 0;
    bit                   pending = 0;
    bit                   prev_busy = 0;
    int                   prev_index;
    int                   prev_angle;
    int                   prev_len;
    int                   last_dir = 0;
    int                   exp_x;
    int                   exp_y;
    bit                   saw_min = 0;
    bit                   saw_max = 0;
    // draw port driver controls
    bit                   bursts_on = 0;
    bit                   sweep_busy = 0;
    int                   sweep_index = 0;
    int                   burst_left = 0;

    tb_clock_gen tb_clock_gen_inst (
        .clock  (clock),
        .resetn (resetn)
    );

    rope_top rope_top_inst (
        .clock      (clock),
        .resetn     (resetn),
        .enable     (enable),
        .fire_key   (fire_key),
        .item_count (item_count),
        .draw_busy  (draw_busy),
        .draw_index (draw_index),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .end_x      (end_x),
        .end_y      (end_y),
        .angle      (angle),
        .rope_len   (rope_len),
        .score      (score),
        .item_rdata (item_rdata)
    );

    function automatic void end_point(input int a, input int len, output int ex, output int ey);
        int f;
        int c;
        f = (a > 90) ? 180 - a : a;
        c = (len * sin_tab[18 - f / 5]) / 256;
        ey = (45 + (len * sin_tab[f / 5]) / 256) & 1023;
        // left of the pivot wraps in 10 bits
        ex = ((a < 90) ? 77 + c : 77 - c) & 1023;
    endfunction

    function automatic bit off_screen(input int ex, input int ey);
        return ex < 2 || ex > 317 || ey > 237;
    endfunction

    function automatic bit hits(input rope_pkg::item_word_t w, input int ex, input int ey);
        int x;
        int y;
        x = int'(w[31:23]);
        y = int'(w[18:11]);
        return w[1] && !w[0] && x < ex && ex <= x + 16 && y < ey && ey <= y + 16;
    endfunction

    function automatic int item_value(input int t);
        if (t == 0) return 10;
        if (t == 1) return 20;
        return 50;
    endfunction

    function automatic int next_angle(input int a, input int dir);
        if (a == 15) return 20;
        if (a == 165) return 160;
        return (dir > 0) ? a + 5 : a - 5;
    endfunction

    // sole driver of the draw port
    always @(posedge clock) begin
        if (bursts_on) begin
            if (burst_left == 0) begin
                draw_busy  <= !draw_busy;
                burst_left = 1 + $urandom % 6;
            end else begin
                burst_left--;
            end
            draw_index <= rope_pkg::item_addr_t'($urandom % 16);
        end else begin
            draw_busy  <= sweep_busy;
            draw_index <= rope_pkg::item_addr_t'(sweep_index);
        end
    end

    always @(negedge clock) begin : monitor
        int a;
        int d;
        rope_pkg::item_word_t base;
        a = int'(angle);
        if (resetn === 1'b1) begin
            if (pending) begin
                assert (int'(end_x) == exp_x && int'(end_y) == exp_y) else begin
                    $display("[ERROR] %0t: end point %0d,%0d, expected %0d,%0d",
                        $time, end_x, end_y, exp_x, exp_y);
                    errors++;
                end
            end
            pending = have_prev && (a != prev_angle || int'(rope_len) != prev_len);
            end_point(a, int'(rope_len), exp_x, exp_y);
            if (have_prev && a != prev_angle) begin
                d = a - prev_angle;
                assert ((d == 5 || d == -5) && a >= 15 && a <= 165) else begin
                    $display("[ERROR] %0t: angle moved %0d to %0d", $time, prev_angle, a);
                    errors++;
                end
                if (last_dir != 0 && d != last_dir) begin
                    // turning only at the limits
                    assert (prev_angle == 15 || prev_angle == 165) else begin
                        $display("[ERROR] %0t: swing reversed at %0d", $time, prev_angle);
                        errors++;
                    end
                end
                last_dir = d;
                if (a == 15) saw_min = 1;
                if (a == 165) saw_max = 1;
            end
            if (prev_busy) begin
                base = shadow[prev_index];
                if (prev_index == hit_idx) begin
                    assert (item_rdata == base || item_rdata == (base | 32'd1)
                        || item_rdata == (base & ~32'd3)) else begin
                        $display("[ERROR] %0t: entry %0d read %h, base %h",
                            $time, prev_index, item_rdata, base);
                        errors++;
                    end
                end else begin
                    assert (item_rdata == base) else begin
                        $display("[ERROR] %0t: entry %0d read %h, expected %h",
                            $time, prev_index, item_rdata, base);
                        errors++;
                    end
                end
            end
            prev_busy  = draw_busy;
            prev_index = int'(draw_index);
            prev_angle = a;
            prev_len   = int'(rope_len);
            have_prev  = 1;
        end
    end

    task automatic note_timeout(input string what);
        if (!timed_out) begin
            $display("timeout: %s never happened", what);
        end
        timed_out = 1;
    endtask

    task automatic wait_angle_change(input int limit);
        int a0;
        int n;
        a0 = int'(angle);
        n = 0;
        while (!timed_out && int'(angle) == a0) begin
            @(negedge clock);
            n++;
            if (n > limit) note_timeout("a change of the swing angle");
        end
    endtask

    // returns just after the swing steps onto the target angle
    task automatic wait_swing_to(input int target);
        int steps;
        steps = 0;
        wait_angle_change(100);
        while (!timed_out && int'(angle) != target) begin
            wait_angle_change(100);
            steps++;
            if (steps > 70) note_timeout("the swing to the drop angle");
        end
    endtask

    task automatic wait_len_change(output int len);
        int l0;
        int n;
        l0 = int'(rope_len);
        n = 0;
        while (!timed_out && int'(rope_len) == l0) begin
            @(negedge clock);
            n++;
            if (n > 3000) note_timeout("a change of the rope length");
        end
        len = int'(rope_len);
    endtask

    task automatic press_fire();
        @(posedge clock);
        fire_key <= 1'b1;
        repeat (2) @(posedge clock);
        fire_key <= 1'b0;
    endtask

    task automatic check_score(input int start_score);
        assert (int'(score) == exp_score) else begin
            $display("[ERROR] %0t: score %0d, expected %0d (was %0d)",
                $time, score, exp_score, start_score);
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int start_errors);
        tests++;
        if (errors != start_errors || timed_out) failed++;
        $display("test %-14s %s, %0d errors", name,
            (errors == start_errors && !timed_out) ? "ok" : "FAILED", errors - start_errors);
    endtask

    task automatic miss_round();
        int a0;
        int nxt;
        int len;
        int old_len;
        int ex;
        int ey;
        bit climbing;
        item_count <= '0;
        a0 = int'(angle);
        wait_angle_change(100);
        nxt = next_angle(int'(angle), int'(angle) - a0);
        wait_angle_change(100);
        press_fire();
        climbing = 1;
        old_len = 20;
        len = 0;
        while (!timed_out && len != 20) begin
            wait_len_change(len);
            if (climbing) begin
                assert (len == old_len + 5) else begin
                    $display("[ERROR] %0t: length %0d after %0d while extending",
                        $time, len, old_len);
                    errors++;
                end
                end_point(nxt, len, ex, ey);
                if (off_screen(ex, ey)) climbing = 0;
            end else begin
                assert (len == old_len - 5) else begin
                    $display("[ERROR] %0t: length %0d after %0d while retracting",
                        $time, len, old_len);
                    errors++;
                end
            end
            old_len = len;
        end
        wait_angle_change(200);
    endtask

    task automatic hit_round(input bit with_bursts);
        int nxt;
        int len;
        int ex;
        int ey;
        int pick;
        int r;
        int x;
        int y;
        int path_x[$];
        int path_y[$];
        rope_pkg::item_word_t w;
        // drop angle picked at random, the fire waits for the swing to reach it
        nxt = 15 + 5 * int'($urandom % 31);
        len = 20;
        path_x.delete();
        path_y.delete();
        for (int i = 0; i < 200; i++) begin
            len += 5;
            end_point(nxt, len, ex, ey);
            if (off_screen(ex, ey)) break;
            path_x.push_back(ex);
            path_y.push_back(ey);
        end
        for (int k = 0; k < 16; k++) begin
            if (k < 4) begin
                pick = $urandom % path_x.size();
                r = $urandom % 16;
                if (r >= path_x[pick]) r = path_x[pick] - 1;
                x = path_x[pick] - 1 - r;
                y = path_y[pick] - 1 - $urandom % 16;
                w = (32'(x) << 23) | (32'(y) << 11) | (32'($urandom % 4) << 2) | 32'd2;
            end else begin
                // hidden filler
                w = (32'(k * 19) << 23) | (32'(k * 13) << 11) | (32'(k % 4) << 2);
            end
            @(posedge clock);
            load_en   <= 1'b1;
            load_addr <= rope_pkg::item_addr_t'(k);
            load_data <= w;
            shadow[k] = w;
        end
        @(posedge clock);
        load_en    <= 1'b0;
        item_count <= 4'd4;
        // first hit in scan order along the predicted path
        for (int p = 0; p < path_x.size() && hit_idx < 0; p++) begin
            for (int e = 0; e < 4 && hit_idx < 0; e++) begin
                if (hits(shadow[e], path_x[p], path_y[p])) hit_idx = e;
            end
        end
        exp_score = (exp_score + item_value(int'(shadow[hit_idx][3:2]))) & 16'hffff;
        if (with_bursts) bursts_on <= 1;
        wait_swing_to(nxt);
        press_fire();
        len = 0;
        while (!timed_out && len != 20) begin
            wait_len_change(len);
        end
        wait_angle_change(500);
        bursts_on <= 0;
        check_score(int'(score));
        shadow[hit_idx] = shadow[hit_idx] & ~32'd3;
        hit_idx = -1;
        for (int k = 0; k < 16; k++) begin
            @(posedge clock);
            sweep_busy  <= 1;
            sweep_index <= k;
        end
        repeat (2) @(posedge clock);
        sweep_busy <= 0;
        repeat (3) @(posedge clock);
    endtask

    initial begin
        int start_errors;
        int n;
        void'($urandom(32'hb7b90af4));
        for (int k = 0; k < 19; k++) begin
            sin_tab[k] = $rtoi($floor(256.0 * $sin(k * 5.0 * 3.14159265358979 / 180.0) + 0.5));
        end
        enable     = 1'b0;
        fire_key   = 1'b0;
        item_count = '0;
        draw_busy  = 1'b0;
        draw_index = '0;
        load_en    = 1'b0;
        load_addr  = '0;
        load_data  = '0;

        n = 0;
        while (!timed_out && resetn !== 1'b1) begin
            @(negedge clock);
            n++;
            if (n > 20) note_timeout("the release of reset");
        end

        start_errors = errors;
        repeat (3) @(negedge clock);
        assert (angle == 8'd90 && rope_len == 10'd20 && score == 16'd0
            && end_x == 10'd77 && end_y == 10'd65) else begin
            $display("[ERROR] %0t: reset state angle %0d len %0d score %0d end %0d,%0d",
                $time, angle, rope_len, score, end_x, end_y);
            errors++;
        end
        @(posedge clock);
        enable <= 1'b1;
        end_test("reset", start_errors);

        start_errors = errors;
        n = 0;
        while (!timed_out && !(saw_min && saw_max)) begin
            @(negedge clock);
            n++;
            if (n > 1500) note_timeout("a full swing to both limits");
        end
        end_test("swing", start_errors);

        start_errors = errors;
        miss_round();
        check_score(0);
        end_test("miss", start_errors);

        start_errors = errors;
        for (int i = 0; i < 3 && !timed_out; i++) hit_round(0);
        end_test("hit", start_errors);

        start_errors = errors;
        for (int i = 0; i < 3 && !timed_out; i++) hit_round(1);
        end_test("draw priority", start_errors);

        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0 && !timed_out) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
rtl/rope_pkg.sv
rtl/swing_trig.sv
rtl/item_table.sv
rtl/key_pulse.sv
rtl/score_counter.sv
rtl/rope_controller.sv
rtl/rope_top.sv
sim/tb_clock_gen.sv
sim/rope_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the rope testbench with Verilator; exit status follows the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module rope_tb -f verilog.f -o rope_sim \
    > build.log 2>&1 \
    && ./obj_dir/rope_sim > sim.log 2>&1
grep -q "All tests passed" sim.log && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }
